// ==== rtl/error_monitor.sv ====
/*
 * Sticky error capture. A tag error outranks a store deadlock, and
 * only the first error seen after reset is kept.
 */
`timescale 1ns/1ps
`default_nettype none

module error_monitor (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 ld_tag_oob_seen,
  input  wire logic                 st_tag_oob_seen,
  input  wire logic                 st_stall,
  output logic                      error_valid,
  output scratchpad_pkg::err_code_e error_code
);

  scratchpad_pkg::err_code_e code_now;

  // Priority encode of this cycle's flags
  always_comb begin
    if (ld_tag_oob_seen || st_tag_oob_seen) begin
      code_now = scratchpad_pkg::err_tag_oob;
    end else if (st_stall) begin
      code_now = scratchpad_pkg::err_store_deadlock;
    end else begin
      code_now = scratchpad_pkg::err_none;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= scratchpad_pkg::err_none;
    end else if (!error_valid && code_now != scratchpad_pkg::err_none) begin
      error_valid <= 1'b1;
      error_code  <= code_now;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/load_port.sv ====
/*
 * Load side of the scratchpad. Data and done leave as one completion,
 * in the same cycle as the request. Tags at or above ld_count are
 * never accepted and are reported as out of range.
 */
`timescale 1ns/1ps
`default_nettype none

module load_port #(
  parameter int ld_count = 3
) (
  input  wire logic                                  ld_req_valid,
  output logic                                       ld_req_ready,
  input  wire scratchpad_pkg::ld_req_t               ld_req,
  output logic                                       ld_data_valid,
  input  wire logic                                  ld_data_ready,
  output scratchpad_pkg::ld_resp_t                   ld_data,
  output logic                                       ld_done_valid,
  input  wire logic                                  ld_done_ready,
  output logic      [scratchpad_pkg::tag_width-1:0]  ld_done_tag,
  output logic      [scratchpad_pkg::addr_width-1:0] rd_addr,
  input  wire logic [scratchpad_pkg::elem_width-1:0] rd_data,
  output logic                                       ld_tag_oob_seen
);

  logic tag_ok;

  assign tag_ok = int'(ld_req.tag) < ld_count;

  // Each output waits on the other's ready so both fire on one edge
  assign ld_req_ready  = tag_ok && ld_data_ready && ld_done_ready;
  assign ld_data_valid = ld_req_valid && tag_ok && ld_done_ready;
  assign ld_done_valid = ld_req_valid && tag_ok && ld_data_ready;

  assign rd_addr     = ld_req.addr;
  assign ld_data     = '{tag: ld_req.tag, data: rd_data};
  assign ld_done_tag = ld_req.tag;

  assign ld_tag_oob_seen = ld_req_valid && !tag_ok;

endmodule

`default_nettype wire

// ==== rtl/scratchpad_array.sv ====
/*
 * Storage words with one asynchronous read and one clocked write.
 * Contents are not reset and read as X until first written.
 */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_array (
  input  wire logic                                  clk,
  input  wire logic [scratchpad_pkg::addr_width-1:0] rd_addr,
  output logic      [scratchpad_pkg::elem_width-1:0] rd_data,
  input  wire scratchpad_pkg::mem_write_t            wr
);

  logic [scratchpad_pkg::elem_width-1:0] mem [scratchpad_pkg::mem_depth];

  // Load path sees the array directly, zero latency
  assign rd_data = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // The pairing logic must never hand over an unknown write address
  a_wr_addr_known: assert property (
    @(posedge clk) wr.en |-> !$isunknown(wr.addr)
  ) else $error("write enabled with unknown address");

endmodule

`default_nettype wire

// ==== rtl/scratchpad_memory.sv ====
/*
 * Tagged scratchpad top level, one load port and one store port.
 * Loads complete in the request cycle, stores after both beats of a
 * tag are queued. The array itself is not reset.
 */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_memory #(
  parameter int ld_count         = 3,
  parameter int st_count         = 2,
  parameter int lsq_depth        = 2,
  parameter int deadlock_timeout = 20
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 ld_req_valid,
  output logic                                      ld_req_ready,
  input  wire scratchpad_pkg::ld_req_t              ld_req,
  output logic                                      ld_data_valid,
  input  wire logic                                 ld_data_ready,
  output scratchpad_pkg::ld_resp_t                  ld_data,
  output logic                                      ld_done_valid,
  input  wire logic                                 ld_done_ready,
  output logic      [scratchpad_pkg::tag_width-1:0] ld_done_tag,
  input  wire logic                                 st_addr_valid,
  output logic                                      st_addr_ready,
  input  wire scratchpad_pkg::st_addr_t             st_addr,
  input  wire logic                                 st_data_valid,
  output logic                                      st_data_ready,
  input  wire scratchpad_pkg::st_data_t             st_data,
  output logic                                      st_done_valid,
  input  wire logic                                 st_done_ready,
  output logic      [scratchpad_pkg::tag_width-1:0] st_done_tag,
  output logic                                      error_valid,
  output scratchpad_pkg::err_code_e                 error_code
);

  logic [scratchpad_pkg::addr_width-1:0] rd_addr;
  logic [scratchpad_pkg::elem_width-1:0] rd_data;
  scratchpad_pkg::mem_write_t            wr;
  logic ld_tag_oob_seen, st_tag_oob_seen, st_stall;

  scratchpad_array u_array (
    .clk     (clk),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (wr)
  );

  load_port #(.ld_count(ld_count)) u_load (
    .ld_req_valid    (ld_req_valid),
    .ld_req_ready    (ld_req_ready),
    .ld_req          (ld_req),
    .ld_data_valid   (ld_data_valid),
    .ld_data_ready   (ld_data_ready),
    .ld_data         (ld_data),
    .ld_done_valid   (ld_done_valid),
    .ld_done_ready   (ld_done_ready),
    .ld_done_tag     (ld_done_tag),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .ld_tag_oob_seen (ld_tag_oob_seen)
  );

  store_pairing #(
    .st_count         (st_count),
    .lsq_depth        (lsq_depth),
    .deadlock_timeout (deadlock_timeout)
  ) u_store (
    .clk             (clk),
    .rst_n           (rst_n),
    .st_addr_valid   (st_addr_valid),
    .st_addr_ready   (st_addr_ready),
    .st_addr         (st_addr),
    .st_data_valid   (st_data_valid),
    .st_data_ready   (st_data_ready),
    .st_data         (st_data),
    .st_done_valid   (st_done_valid),
    .st_done_ready   (st_done_ready),
    .st_done_tag     (st_done_tag),
    .wr              (wr),
    .st_tag_oob_seen (st_tag_oob_seen),
    .st_stall        (st_stall)
  );

  error_monitor u_errors (
    .clk             (clk),
    .rst_n           (rst_n),
    .ld_tag_oob_seen (ld_tag_oob_seen),
    .st_tag_oob_seen (st_tag_oob_seen),
    .st_stall        (st_stall),
    .error_valid     (error_valid),
    .error_code      (error_code)
  );

endmodule

`default_nettype wire

// ==== rtl/scratchpad_pkg.sv ====
/*
 * Shared widths, beat structs and error codes for the tagged scratchpad.
 * The tag is fixed at 2 bits, so at most 4 logical ports can be named.
 * Only the low addr_width bits of an address index the array.
 */
`default_nettype none

package scratchpad_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int tag_width  = 2;
  localparam int addr_width = 6;
  localparam int mem_depth  = 1 << addr_width;
  localparam int elem_width = 32;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [addr_width-1:0] addr;
  } ld_req_t;

  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [addr_width-1:0] addr;
  } st_addr_t;

  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [elem_width-1:0] data;
  } st_data_t;

  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [elem_width-1:0] data;
  } ld_resp_t;

  // Write command from store pairing into the array
  typedef struct packed {
    logic                  en;
    logic [addr_width-1:0] addr;
    logic [elem_width-1:0] data;
  } mem_write_t;

  typedef enum logic [7:0] {
    err_none           = 8'd0,
    err_tag_oob        = 8'd1,
    err_store_deadlock = 8'd2
  } err_code_e;

endpackage

`default_nettype wire

// ==== rtl/store_pairing.sv ====
/*
 * Routes store beats to per-tag queues and retires one complete
 * address/data pair per cycle, lowest tag first. The array write is
 * issued on the same edge as the done transfer. st_count is at most 4.
 */
`timescale 1ns/1ps
`default_nettype none

module store_pairing #(
  parameter int st_count         = 2,
  parameter int lsq_depth        = 2,
  parameter int deadlock_timeout = 20
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 st_addr_valid,
  output logic                                      st_addr_ready,
  input  wire scratchpad_pkg::st_addr_t             st_addr,
  input  wire logic                                 st_data_valid,
  output logic                                      st_data_ready,
  input  wire scratchpad_pkg::st_data_t             st_data,
  output logic                                      st_done_valid,
  input  wire logic                                 st_done_ready,
  output logic      [scratchpad_pkg::tag_width-1:0] st_done_tag,
  output scratchpad_pkg::mem_write_t                wr,
  output logic                                      st_tag_oob_seen,
  output logic                                      st_stall
);

  localparam int tag_span = 1 << scratchpad_pkg::tag_width;

  logic [st_count-1:0] addr_full, data_full, pair_ready, stalled;
  logic [st_count-1:0] addr_enq, data_enq, pair_deq;
  logic [st_count-1:0][scratchpad_pkg::addr_width-1:0] head_addr;
  logic [st_count-1:0][scratchpad_pkg::elem_width-1:0] head_data;
  logic [tag_span-1:0] addr_full_ext, data_full_ext;
  logic                addr_tag_ok, data_tag_ok;
  logic                done_fire;
  logic [scratchpad_pkg::tag_width-1:0] grant_tag;

  // ----------------------------------------------------------
  // Beat acceptance
  // ----------------------------------------------------------
  assign addr_tag_ok = int'(st_addr.tag) < st_count;
  assign data_tag_ok = int'(st_data.tag) < st_count;

  // Padded so an out-of-range tag still indexes a real bit
  assign addr_full_ext = tag_span'(addr_full);
  assign data_full_ext = tag_span'(data_full);

  // Readies look at tag and fullness only, never at valid
  assign st_addr_ready = addr_tag_ok && !addr_full_ext[st_addr.tag];
  assign st_data_ready = data_tag_ok && !data_full_ext[st_data.tag];

  assign st_tag_oob_seen = (st_addr_valid && !addr_tag_ok) ||
                           (st_data_valid && !data_tag_ok);

  // ----------------------------------------------------------
  // Fixed-priority grant, lowest ready tag wins
  // ----------------------------------------------------------
  always_comb begin
    grant_tag = '0;
    for (int i = st_count - 1; i >= 0; i--) begin
      if (pair_ready[i]) grant_tag = scratchpad_pkg::tag_width'(i);
    end
  end

  assign st_done_valid = |pair_ready;
  assign st_done_tag   = grant_tag;
  assign done_fire     = st_done_valid && st_done_ready;

  assign wr.en   = done_fire;
  assign wr.addr = head_addr[grant_tag];
  assign wr.data = head_data[grant_tag];

  assign st_stall = |stalled;

  for (genvar g = 0; g < st_count; g++) begin : g_tag
    assign addr_enq[g] = st_addr_valid && st_addr_ready &&
                         (st_addr.tag == scratchpad_pkg::tag_width'(g));
    assign data_enq[g] = st_data_valid && st_data_ready &&
                         (st_data.tag == scratchpad_pkg::tag_width'(g));
    assign pair_deq[g] = done_fire && (grant_tag == scratchpad_pkg::tag_width'(g));

    store_tag_queue #(
      .lsq_depth        (lsq_depth),
      .deadlock_timeout (deadlock_timeout)
    ) u_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr_enq   (addr_enq[g]),
      .addr_in    (st_addr.addr),
      .data_enq   (data_enq[g]),
      .data_in    (st_data.data),
      .pair_deq   (pair_deq[g]),
      .addr_full  (addr_full[g]),
      .data_full  (data_full[g]),
      .pair_ready (pair_ready[g]),
      .head_addr  (head_addr[g]),
      .head_data  (head_data[g]),
      .stalled    (stalled[g])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/store_tag_queue.sv ====
/*
 * Address and data FIFOs for one store tag, popped together as a pair.
 * The caller must not enqueue a full side or pop without pair_ready.
 * stalled stays high while one side alone has waited deadlock_timeout
 * cycles or more.
 */
`timescale 1ns/1ps
`default_nettype none

module store_tag_queue #(
  parameter int lsq_depth        = 2,
  parameter int deadlock_timeout = 20
) (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  addr_enq,
  input  wire logic [scratchpad_pkg::addr_width-1:0] addr_in,
  input  wire logic                                  data_enq,
  input  wire logic [scratchpad_pkg::elem_width-1:0] data_in,
  input  wire logic                                  pair_deq,
  output logic                                       addr_full,
  output logic                                       data_full,
  output logic                                       pair_ready,
  output logic      [scratchpad_pkg::addr_width-1:0] head_addr,
  output logic      [scratchpad_pkg::elem_width-1:0] head_data,
  output logic                                       stalled
);

  localparam int qw = $clog2(lsq_depth > 1 ? lsq_depth : 2);
  localparam int tw = $clog2(deadlock_timeout + 1);

  logic [scratchpad_pkg::addr_width-1:0] addr_q [lsq_depth];
  logic [scratchpad_pkg::elem_width-1:0] data_q [lsq_depth];
  logic [qw-1:0] addr_wr, addr_rd, data_wr, data_rd;
  logic [qw:0]   addr_cnt, data_cnt;
  logic [tw-1:0] wait_cnt;
  logic          one_sided;

  function automatic logic [qw-1:0] next_ptr(input logic [qw-1:0] p);
    return (p == qw'(lsq_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Pointers and counts, both sides pop on pair_deq
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr  <= '0;
      addr_rd  <= '0;
      addr_cnt <= '0;
      data_wr  <= '0;
      data_rd  <= '0;
      data_cnt <= '0;
    end else begin
      if (addr_enq) addr_wr <= next_ptr(addr_wr);
      if (data_enq) data_wr <= next_ptr(data_wr);
      if (pair_deq) begin
        addr_rd <= next_ptr(addr_rd);
        data_rd <= next_ptr(data_rd);
      end
      addr_cnt <= addr_cnt + (qw+1)'(addr_enq) - (qw+1)'(pair_deq);
      data_cnt <= data_cnt + (qw+1)'(data_enq) - (qw+1)'(pair_deq);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (addr_enq) addr_q[addr_wr] <= addr_in;
    if (data_enq) data_q[data_wr] <= data_in;
  end

  assign addr_full  = addr_cnt == (qw+1)'(lsq_depth);
  assign data_full  = data_cnt == (qw+1)'(lsq_depth);
  assign pair_ready = (addr_cnt != '0) && (data_cnt != '0);
  assign head_addr  = addr_q[addr_rd];
  assign head_data  = data_q[data_rd];

  // ----------------------------------------------------------
  // One-sided wait timer, saturates at the timeout
  // ----------------------------------------------------------
  assign one_sided = (addr_cnt != '0) != (data_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!one_sided) begin
      wait_cnt <= '0;
    end else if (wait_cnt != tw'(deadlock_timeout)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign stalled = wait_cnt == tw'(deadlock_timeout);

  a_no_addr_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) addr_enq |-> !addr_full
  ) else $error("address beat enqueued into full queue");

  a_no_data_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) data_enq |-> !data_full
  ) else $error("data beat enqueued into full queue");

  a_deq_only_paired: assert property (
    @(posedge clk) disable iff (!rst_n) pair_deq |-> pair_ready
  ) else $error("pair popped without both sides present");

endmodule

`default_nettype wire

// ==== scratchpad_memory.f ====
rtl/scratchpad_pkg.sv
rtl/scratchpad_array.sv
rtl/load_port.sv
rtl/store_tag_queue.sv
rtl/store_pairing.sv
rtl/error_monitor.sv
rtl/scratchpad_memory.sv
tb/scratchpad_memory_tb.sv

// ==== tb/scratchpad_memory_tb.sv ====
/*
 * Vector-driven testbench for the tagged scratchpad.
 * Must run from the project root so the vector file path resolves.
 * Store done is only released by done_release lines, so every store
 * pair needs one before it reaches the array.
 */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_memory_tb;

  localparam int ld_ports         = 3;
  localparam int max_vectors      = 128;
  localparam int handshake_limit  = 20;
  localparam int error_wait_limit = 60;

  logic clk = 1'b0;
  logic rst_n;
  logic ld_req_valid, ld_req_ready;
  logic ld_data_valid, ld_data_ready;
  logic ld_done_valid, ld_done_ready;
  logic st_addr_valid, st_addr_ready;
  logic st_data_valid, st_data_ready;
  logic st_done_valid, st_done_ready;
  logic error_valid;
  logic [scratchpad_pkg::tag_width-1:0] ld_done_tag, st_done_tag;
  scratchpad_pkg::ld_req_t   ld_req;
  scratchpad_pkg::ld_resp_t  ld_data;
  scratchpad_pkg::st_addr_t  st_addr;
  scratchpad_pkg::st_data_t  st_data;
  scratchpad_pkg::err_code_e error_code;

  // One entry per vector line
  logic [8*16-1:0] vec_op [max_vectors];
  logic [31:0] vec_tag [max_vectors];
  logic [31:0] vec_addr [max_vectors];
  logic [31:0] vec_data [max_vectors];
  logic [31:0] vec_exp [max_vectors];
  logic [31:0] vec_err [max_vectors];
  int vec_count = 0;

  int mismatch_count = 0;
  int other_count    = 0;
  int cycle_count    = 0;
  int cycle_limit    = 0;

  scratchpad_memory #(
    .ld_count         (ld_ports),
    .st_count         (2),
    .deadlock_timeout (20)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_req_valid  (ld_req_valid),
    .ld_req_ready  (ld_req_ready),
    .ld_req        (ld_req),
    .ld_data_valid (ld_data_valid),
    .ld_data_ready (ld_data_ready),
    .ld_data       (ld_data),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .ld_done_tag   (ld_done_tag),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr       (st_addr),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data       (st_data),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done_tag   (st_done_tag),
    .error_valid   (error_valid),
    .error_code    (error_code)
  );

  always #5 clk = ~clk;

  // Watchdog, limit set once the vectors are known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles before the vectors were done", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    assert (got === want) else begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_error_state(input logic [31:0] want_code);
    check_value(32'(error_valid), 32'(want_code != 0), "error_valid");
    check_value(32'(error_code), want_code, "error_code");
  endtask

  // ----------------------------------------------------------
  // Operations, each starts 1 ns after a rising edge
  // ----------------------------------------------------------
  task automatic drive_load(input logic [31:0] tag, input logic [31:0] addr,
                            input int hold, input logic [31:0] want_data);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    ld_req_valid = 1'b1;
    ld_req.tag   = tag[1:0];
    ld_req.addr  = addr[5:0];
    if (tag >= ld_ports) begin
      // Bad tag, request is held and must never be taken
      repeat (hold) begin
        @(negedge clk);
        check_value(32'(ld_req_ready), 0, "ld_req_ready on bad tag");
        check_value(32'(ld_done_valid), 0, "ld_done_valid on bad tag");
      end
    end else begin
      if (hold > 0) begin
        ld_data_ready = 1'b0;
        repeat (hold) begin
          @(negedge clk);
          check_value(32'(ld_req_ready), 0, "ld_req_ready under back-pressure");
          check_value(32'(ld_done_valid), 0, "ld_done_valid under back-pressure");
        end
        @(posedge clk);
        #1;
        ld_data_ready = 1'b1;
      end
      @(negedge clk);
      while (!ld_req_ready && waited < handshake_limit) begin
        @(negedge clk);
        waited++;
      end
      if (ld_req_ready) begin
        check_value(32'(ld_data_valid), 1, "ld_data_valid");
        check_value(32'(ld_done_valid), 1, "ld_done_valid");
        check_value(ld_data.data, want_data, "ld_data.data");
        check_value(32'(ld_data.tag), tag, "ld_data.tag");
        check_value(32'(ld_done_tag), tag, "ld_done_tag");
      end else begin
        other_count++;
        $display("Load request on tag %0d was never accepted", tag);
      end
    end
    @(posedge clk);
    #1;
    ld_req_valid = 1'b0;
  endtask

  task automatic drive_store_addr(input logic [31:0] tag, input logic [31:0] addr);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    st_addr_valid = 1'b1;
    st_addr.tag   = tag[1:0];
    st_addr.addr  = addr[5:0];
    @(negedge clk);
    while (!st_addr_ready && waited < handshake_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!st_addr_ready) begin
      other_count++;
      $display("Store address beat on tag %0d was never accepted", tag);
    end
    @(posedge clk);
    #1;
    st_addr_valid = 1'b0;
  endtask

  task automatic drive_store_data(input logic [31:0] tag, input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    st_data_valid = 1'b1;
    st_data.tag   = tag[1:0];
    st_data.data  = data;
    @(negedge clk);
    while (!st_data_ready && waited < handshake_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!st_data_ready) begin
      other_count++;
      $display("Store data beat on tag %0d was never accepted", tag);
    end
    @(posedge clk);
    #1;
    st_data_valid = 1'b0;
  endtask

  task automatic hold_done(input logic [31:0] want_valid);
    @(posedge clk);
    #1;
    st_done_ready = 1'b0;
    @(negedge clk);
    check_value(32'(st_done_valid), want_valid, "st_done_valid while held");
  endtask

  // Lets exactly one store completion through
  task automatic release_done(input logic [31:0] want_tag);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    st_done_ready = 1'b1;
    @(negedge clk);
    while (!st_done_valid && waited < handshake_limit) begin
      @(negedge clk);
      waited++;
    end
    if (st_done_valid) begin
      check_value(32'(st_done_tag), want_tag, "st_done_tag");
    end else begin
      other_count++;
      $display("No store completion was offered while done was released");
    end
    @(posedge clk);
    #1;
    st_done_ready = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value(32'(st_done_valid), 0, "st_done_valid after reset");
  endtask

  task automatic await_error();
    int waited;
    waited = 0;
    while (!error_valid && waited < error_wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!error_valid) begin
      other_count++;
      $display("No error was reported within %0d cycles", error_wait_limit);
    end
  endtask

  // ----------------------------------------------------------
  // Vector loading and main sequence
  // ----------------------------------------------------------
  task automatic read_vectors();
    int fd;
    int fields;
    logic [8*120-1:0] line_buf;
    logic [8*16-1:0] f_op;
    logic [31:0] f_tag, f_addr, f_data, f_exp, f_err;
    fd = $fopen("tb/scratchpad_vectors.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("Vector file tb/scratchpad_vectors.txt could not be opened");
    end else begin
      while (!$feof(fd) && vec_count < max_vectors) begin
        line_buf = '0;
        void'($fgets(line_buf, fd));
        fields = $sscanf(line_buf, "%s %h %h %h %h %h",
                         f_op, f_tag, f_addr, f_data, f_exp, f_err);
        // Comment and blank lines never fill all six fields
        if (fields == 6) begin
          vec_op[vec_count]   = f_op;
          vec_tag[vec_count]  = f_tag;
          vec_addr[vec_count] = f_addr;
          vec_data[vec_count] = f_data;
          vec_exp[vec_count]  = f_exp;
          vec_err[vec_count]  = f_err;
          vec_count++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    ld_req_valid  = 1'b0;
    ld_req        = '0;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    st_addr_valid = 1'b0;
    st_addr       = '0;
    st_data_valid = 1'b0;
    st_data       = '0;
    st_done_ready = 1'b0;

    read_vectors();
    cycle_limit = vec_count * 40 + 200;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < vec_count; i++) begin
      if (vec_op[i] == "load") begin
        drive_load(vec_tag[i], vec_addr[i], int'(vec_data[i]), vec_exp[i]);
      end else if (vec_op[i] == "store_addr") begin
        drive_store_addr(vec_tag[i], vec_addr[i]);
      end else if (vec_op[i] == "store_data") begin
        drive_store_data(vec_tag[i], vec_data[i]);
      end else if (vec_op[i] == "done_hold") begin
        hold_done(vec_exp[i]);
      end else if (vec_op[i] == "done_release") begin
        release_done(vec_exp[i]);
      end else if (vec_op[i] == "reset") begin
        apply_reset();
      end else if (vec_op[i] == "wait_error") begin
        await_error();
      end else begin
        other_count++;
        $display("Unknown operation in vector %0d", i);
      end
      check_error_state(vec_err[i]);
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/scratchpad_vectors.txt ====
# Columns: op tag addr data expected err, all fields in hex
# load: data = cycles with ld_data_ready low, or cycles a bad tag is held
# done_hold expects st_done_valid, done_release expects st_done_tag
# Write then read on several addresses
store_addr   0 01 00000000 00000000 0
store_data   0 00 cafe0001 00000000 0
done_release 0 00 00000000 00000000 0
store_addr   1 02 00000000 00000000 0
store_data   1 00 12345678 00000000 0
done_release 0 00 00000000 00000001 0
store_addr   0 03 00000000 00000000 0
store_data   0 00 a5a55a5a 00000000 0
done_release 0 00 00000000 00000000 0
load         0 01 00000000 cafe0001 0
load         1 02 00000000 12345678 0
load         2 03 00000000 a5a55a5a 0
# Two address beats before two data beats on tag 1
store_addr   1 08 00000000 00000000 0
store_addr   1 09 00000000 00000000 0
store_data   1 00 11110008 00000000 0
store_data   1 00 22220009 00000000 0
done_release 0 00 00000000 00000001 0
done_release 0 00 00000000 00000001 0
load         0 08 00000000 11110008 0
load         0 09 00000000 22220009 0
# Lowest tag retires first while done is held
done_hold    0 00 00000000 00000000 0
store_addr   1 10 00000000 00000000 0
store_data   1 00 0b0b0010 00000000 0
store_addr   0 11 00000000 00000000 0
store_data   0 00 0a0a0011 00000000 0
done_hold    0 00 00000000 00000001 0
done_release 0 00 00000000 00000000 0
done_release 0 00 00000000 00000001 0
load         1 10 00000000 0b0b0010 0
load         1 11 00000000 0a0a0011 0
# Load held off by ld_data_ready
load         2 01 00000004 cafe0001 0
# Out-of-range load tag, error stays latched
load         3 05 00000003 00000000 1
load         0 01 00000000 cafe0001 1
# Store deadlock on tag 1 after a fresh reset
reset        0 00 00000000 00000000 0
store_addr   1 20 00000000 00000000 0
wait_error   0 00 00000000 00000000 2
